// File: src/lb_bus_pkg.sv
// Local-bus widths and address map
// Address word union with separate read and write decode views
// Read regions, write page and write register indices
`default_nettype none

package lb_bus_pkg;

	// Bus widths
	localparam int LB_AW = 24;
	localparam int LB_DW = 32;

	// Read decode view, region in the top byte
	typedef struct packed {
		logic [7:0]        region;
		logic [LB_AW-13:0] unused;
		logic [3:0]        index;
	} lb_rd_view_t;

	// Write decode view, page in the top nibble
	typedef struct packed {
		logic [3:0]       page;
		logic [LB_AW-9:0] unused;
		logic [3:0]       index;
	} lb_wr_view_t;

	// Same address word, two decodes
	typedef union packed {
		lb_rd_view_t rd;
		lb_wr_view_t wr;
	} lb_addr_u;

	// Read regions
	localparam logic [7:0] REGION_IBADGE = 8'h01;
	localparam logic [7:0] REGION_OBADGE = 8'h02;
	localparam logic [7:0] REGION_BANK0  = 8'h11;

	// Writable page and its registers
	localparam logic [3:0] PAGE_CTRL     = 4'd0;
	localparam logic [3:0] WREG_LED_USER = 4'd1;
	localparam logic [3:0] WREG_LED1_DF  = 4'd2;
	localparam logic [3:0] WREG_LED2_DF  = 4'd3;
	localparam logic [3:0] WREG_DBG_RST  = 4'd4;

	// Returned for any region not mapped
	localparam logic [LB_DW-1:0] LB_UNMAPPED = 32'hdeadbeef;

endpackage

`default_nettype wire

// File: src/lb_diag_pkg.sv
// Diagnostic constants
// Identification string words and bank-0 filler
// Badge and trace word field widths, default block widths
`default_nettype none

package lb_diag_pkg;

	// "Hello world!(::)" as four bus words
	localparam logic [31:0] ID_WORD0  = "Hell";
	localparam logic [31:0] ID_WORD1  = "o wo";
	localparam logic [31:0] ID_WORD2  = "rld!";
	localparam logic [31:0] ID_WORD3  = "(::)";
	// Bank-0 indices with nothing behind them
	localparam logic [31:0] ID_FILLER = "zzzz";

	// One badge byte
	localparam int BADGE_W = 8;
	// Cross-domain fault counter
	localparam int FAULT_CNT_W = 16;

	// Trace word: byte in 7:0, recorded count in 15:8, rest zero
	localparam int TRACE_CNT_W = 8;

	// Block defaults, overridden from the top level
	// 2^27 cycles is roughly one second at 125 MHz
	localparam int DEF_REFCNT_WIDTH = 27;
	localparam int DEF_FREQ_WIDTH   = 32;
	localparam int DEF_TRACE_AW     = 4;

endpackage

`default_nettype wire

// File: src/freq_count.sv
// Frequency counter for a foreign clock
// Gray-coded edge count crossed into the bus clock
// Difference per gate window of 2^REFCNT_WIDTH bus cycles
`timescale 1ns/10ps
`default_nettype none

module freq_count
	import lb_diag_pkg::*;
#(
	parameter int REFCNT_WIDTH = DEF_REFCNT_WIDTH,
	parameter int FREQ_WIDTH   = DEF_FREQ_WIDTH
) (
	input  wire                   sysclk,
	input  wire                   rst_n,
	input  wire                   f_in,
	output logic [FREQ_WIDTH-1:0] frequency
);

	// Reset for the f_in domain, async assert, sync release
	logic [1:0] fin_rst_sync;
	logic       fin_rst_n;

	// Edge counter in the f_in domain
	logic [FREQ_WIDTH-1:0] bin_cnt;
	logic [FREQ_WIDTH-1:0] bin_next;
	logic [FREQ_WIDTH-1:0] gray_cnt;

	// Bus-clock side
	logic [REFCNT_WIDTH-1:0] refcnt;
	logic                    window_end;
	logic [FREQ_WIDTH-1:0]   gray_s1;
	logic [FREQ_WIDTH-1:0]   gray_s2;
	logic [FREQ_WIDTH-1:0]   sync_bin;
	logic [FREQ_WIDTH-1:0]   prev_bin;

	always_ff @(posedge f_in or negedge rst_n) begin
		if (!rst_n) begin
			fin_rst_sync <= '0;
		end else begin
			fin_rst_sync <= {fin_rst_sync[0], 1'b1};
		end
	end
	assign fin_rst_n = fin_rst_sync[1];

	assign bin_next = bin_cnt + 1'b1;

	// Gray value registered so only one bit moves per f_in cycle
	always_ff @(posedge f_in or negedge fin_rst_n) begin
		if (!fin_rst_n) begin
			bin_cnt  <= '0;
			gray_cnt <= '0;
		end else begin
			bin_cnt  <= bin_next;
			gray_cnt <= bin_next ^ (bin_next >> 1);
		end
	end

	// Gray back to binary, MSB down
	always_comb begin
		sync_bin[FREQ_WIDTH-1] = gray_s2[FREQ_WIDTH-1];
		for (int i = FREQ_WIDTH - 2; i >= 0; i--) begin
			sync_bin[i] = sync_bin[i+1] ^ gray_s2[i];
		end
	end

	// Gate window closes when the reference counter is all ones
	assign window_end = &refcnt;

	always_ff @(posedge sysclk or negedge rst_n) begin
		if (!rst_n) begin
			refcnt    <= '0;
			gray_s1   <= '0;
			gray_s2   <= '0;
			prev_bin  <= '0;
			frequency <= '0;
		end else begin
			refcnt  <= refcnt + 1'b1;
			// Two-flop synchronizer
			gray_s1 <= gray_cnt;
			gray_s2 <= gray_s1;
			if (window_end) begin
				// Edges seen since the previous window, wraps cleanly
				frequency <= sync_bin - prev_bin;
				prev_bin  <= sync_bin;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/badge_trace.sv
// Badge trace buffer
// Circular memory of strobed bytes written on the badge clock
// Saturating count crossed in gray code to the bus clock
// Bus-side registered readout of entry and count
`timescale 1ns/10ps
`default_nettype none

module badge_trace
	import lb_bus_pkg::*;
	import lb_diag_pkg::*;
#(
	parameter int TRACE_AW = DEF_TRACE_AW
) (
	input  wire                 badge_clk,
	input  wire                 rst_n,
	input  wire                 trace_reset,
	input  wire                 badge_stb,
	input  wire [BADGE_W-1:0]   badge_data,
	input  wire                 lb_clk,
	input  wire [TRACE_AW-1:0]  lb_addr,
	input  wire                 lb_rd,
	output logic [LB_DW-1:0]    lb_result
);

	localparam int CW = TRACE_AW + 1;
	localparam logic [CW-1:0] DEPTH = CW'(2 ** TRACE_AW);

	// Trace storage, no reset
	logic [BADGE_W-1:0] mem [2**TRACE_AW];

	// Badge-domain resets
	logic [1:0] rst_sync;
	logic       badge_rst_n;
	logic [1:0] clr_sync;
	logic       clr;

	// Badge-domain pointer and count
	logic [TRACE_AW-1:0] wr_ptr;
	logic [TRACE_AW-1:0] ptr_next;
	logic [CW-1:0]       wr_cnt;
	logic [CW-1:0]       cnt_next;
	logic [CW-1:0]       cnt_gray;

	// Bus-domain copy of the count
	logic [CW-1:0] gray_s1;
	logic [CW-1:0] gray_s2;
	logic [CW-1:0] cnt_bin;

	always_ff @(posedge badge_clk or negedge rst_n) begin
		if (!rst_n) begin
			rst_sync <= '0;
		end else begin
			rst_sync <= {rst_sync[0], 1'b1};
		end
	end
	assign badge_rst_n = rst_sync[1];

	// Debug reset comes from the bus clock
	always_ff @(posedge badge_clk or negedge badge_rst_n) begin
		if (!badge_rst_n) begin
			clr_sync <= '0;
		end else begin
			clr_sync <= {clr_sync[0], trace_reset};
		end
	end
	assign clr = clr_sync[1];

	// Pointer wraps, count stops at the depth
	always_comb begin
		ptr_next = wr_ptr;
		cnt_next = wr_cnt;
		if (clr) begin
			ptr_next = '0;
			cnt_next = '0;
		end else if (badge_stb) begin
			ptr_next = wr_ptr + 1'b1;
			if (wr_cnt != DEPTH) begin
				cnt_next = wr_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge badge_clk or negedge badge_rst_n) begin
		if (!badge_rst_n) begin
			wr_ptr   <= '0;
			wr_cnt   <= '0;
			cnt_gray <= '0;
		end else begin
			wr_ptr   <= ptr_next;
			wr_cnt   <= cnt_next;
			cnt_gray <= cnt_next ^ (cnt_next >> 1);
		end
	end

	// Bytes dropped while a clear is pending
	always_ff @(posedge badge_clk) begin
		if (badge_stb && !clr) begin
			mem[wr_ptr] <= badge_data;
		end
	end

	always_ff @(posedge lb_clk or negedge rst_n) begin
		if (!rst_n) begin
			gray_s1 <= '0;
			gray_s2 <= '0;
		end else begin
			gray_s1 <= cnt_gray;
			gray_s2 <= gray_s1;
		end
	end

	always_comb begin
		cnt_bin[CW-1] = gray_s2[CW-1];
		for (int i = CW - 2; i >= 0; i--) begin
			cnt_bin[i] = cnt_bin[i+1] ^ gray_s2[i];
		end
	end

	// Readout lands together with the slave's bank-0 stage
	always_ff @(posedge lb_clk) begin
		if (lb_rd) begin
			lb_result <= {{(LB_DW-BADGE_W-TRACE_CNT_W){1'b0}},
				TRACE_CNT_W'(cnt_bin), mem[lb_addr]};
		end
	end

endmodule

`default_nettype wire

// File: src/lb_demo_slave.sv
// Local-bus demo slave
// Two-stage read path over identification, health and trace words
// Cross-domain fault counter
// Control page writes and PWM LED drive
`timescale 1ns/10ps
`default_nettype none

module lb_demo_slave
	import lb_bus_pkg::*;
	import lb_diag_pkg::*;
#(
	parameter int FREQ_WIDTH = DEF_FREQ_WIDTH
) (
	input  wire                   clk,
	input  wire                   rst_n,
	// Local bus
	input  lb_addr_u              addr,
	input  wire                   control_strobe,
	input  wire                   control_rd,
	input  wire [LB_DW-1:0]       data_out,
	output logic [LB_DW-1:0]      data_in,
	// Health inputs
	input  wire                   xdomain_fault,
	input  wire                   tx_mac_done,
	input  wire [FREQ_WIDTH-1:0]  tx_freq,
	// Trace readouts, already registered
	input  wire [LB_DW-1:0]       ibadge_word,
	input  wire [LB_DW-1:0]       obadge_word,
	// To the traces
	output logic                  lb_rd,
	output logic                  trace_reset,
	// LEDs
	output logic                  led_user_mode,
	output logic                  led1,
	output logic                  led2
);

	logic                   wr_ctrl;
	logic [FAULT_CNT_W-1:0] fault_cnt;

	// Read pipeline
	lb_addr_u               addr_r;
	logic                   rd_r;
	logic [LB_DW-1:0]       bank0;

	// Write registers
	logic [7:0] led1_df;
	logic [7:0] led2_df;

	// PWM phase
	logic [9:0] led_cc;

	assign lb_rd   = control_strobe & control_rd;
	// Only page 0 is writable
	assign wr_ctrl = control_strobe & ~control_rd & (addr.wr.page == PAGE_CTRL);

	// Burst expected at startup while clock trees settle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fault_cnt <= '0;
		end else if (xdomain_fault) begin
			fault_cnt <= fault_cnt + 1'b1;
		end
	end

	// Address and read flag delayed to line up with stage one
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_r <= 1'b0;
		end else begin
			rd_r <= lb_rd;
		end
	end

	always_ff @(posedge clk) begin
		addr_r <= addr;
	end

	// Stage one, bank 0 by index
	always_ff @(posedge clk) begin
		if (lb_rd) begin
			case (addr.rd.index)
				4'd0: bank0 <= ID_WORD0;
				4'd1: bank0 <= ID_WORD1;
				4'd2: bank0 <= ID_WORD2;
				4'd3: bank0 <= ID_WORD3;
				4'd4: bank0 <= LB_DW'(fault_cnt);
				4'd5: bank0 <= LB_DW'(tx_freq);
				4'd6: bank0 <= LB_DW'(tx_mac_done);
				default: bank0 <= ID_FILLER;
			endcase
		end
	end

	// Stage two, pick by region
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			data_in <= '0;
		end else if (rd_r) begin
			case (addr_r.rd.region)
				REGION_IBADGE: data_in <= ibadge_word;
				REGION_OBADGE: data_in <= obadge_word;
				REGION_BANK0:  data_in <= bank0;
				default:       data_in <= LB_UNMAPPED;
			endcase
		end
	end

	// Control writes take effect on the strobe edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_user_mode <= 1'b0;
			led1_df       <= '0;
			led2_df       <= '0;
			trace_reset   <= 1'b0;
		end else if (wr_ctrl) begin
			case (addr.wr.index)
				WREG_LED_USER: led_user_mode <= data_out[0];
				WREG_LED1_DF:  led1_df       <= data_out[7:0];
				WREG_LED2_DF:  led2_df       <= data_out[7:0];
				WREG_DBG_RST:  trace_reset   <= data_out[0];
				default:       ;
			endcase
		end
	end

	// 1024-cycle PWM period, high for 4*df cycles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			led_cc <= '0;
			led1   <= 1'b0;
			led2   <= 1'b0;
		end else begin
			led_cc <= led_cc + 1'b1;
			led1   <= led_cc < {led1_df, 2'b00};
			led2   <= led_cc < {led2_df, 2'b00};
		end
	end

endmodule

`default_nettype wire

// File: src/lb_demo_top.sv
// Demo peripheral top level
// Slave, badge-clock frequency counter and two badge traces
// Sets the gate window, result width and trace depth
`timescale 1ns/10ps
`default_nettype none

module lb_demo_top
	import lb_bus_pkg::*;
	import lb_diag_pkg::*;
#(
	parameter int REFCNT_WIDTH = DEF_REFCNT_WIDTH,
	parameter int FREQ_WIDTH   = DEF_FREQ_WIDTH,
	// Depth bounded by the 4-bit bus index
	parameter int TRACE_AW     = DEF_TRACE_AW
) (
	input  wire                clk,
	input  wire                rst_n,
	// Local bus
	input  lb_addr_u           addr,
	input  wire                control_strobe,
	input  wire                control_rd,
	input  wire [LB_DW-1:0]    data_out,
	output logic [LB_DW-1:0]   data_in,
	// Badge ports
	input  wire                ibadge_clk,
	input  wire                ibadge_stb,
	input  wire [BADGE_W-1:0]  ibadge_data,
	input  wire                obadge_stb,
	input  wire [BADGE_W-1:0]  obadge_data,
	// Health
	input  wire                xdomain_fault,
	input  wire                tx_mac_done,
	// LEDs
	output logic               led_user_mode,
	output logic               led1,
	output logic               led2
);

	logic                  lb_rd;
	logic                  trace_reset;
	logic [FREQ_WIDTH-1:0] tx_freq;
	logic [LB_DW-1:0]      ibadge_word;
	logic [LB_DW-1:0]      obadge_word;

	lb_demo_slave #(
		.FREQ_WIDTH(FREQ_WIDTH)
	) u_slave (
		.clk            (clk),
		.rst_n          (rst_n),
		.addr           (addr),
		.control_strobe (control_strobe),
		.control_rd     (control_rd),
		.data_out       (data_out),
		.data_in        (data_in),
		.xdomain_fault  (xdomain_fault),
		.tx_mac_done    (tx_mac_done),
		.tx_freq        (tx_freq),
		.ibadge_word    (ibadge_word),
		.obadge_word    (obadge_word),
		.lb_rd          (lb_rd),
		.trace_reset    (trace_reset),
		.led_user_mode  (led_user_mode),
		.led1           (led1),
		.led2           (led2)
	);

	// Badge clock measured against the bus clock
	freq_count #(
		.REFCNT_WIDTH(REFCNT_WIDTH),
		.FREQ_WIDTH  (FREQ_WIDTH)
	) u_freq (
		.sysclk    (clk),
		.rst_n     (rst_n),
		.f_in      (ibadge_clk),
		.frequency (tx_freq)
	);

	// Input badges on their own clock
	badge_trace #(
		.TRACE_AW(TRACE_AW)
	) u_ibadge_trace (
		.badge_clk   (ibadge_clk),
		.rst_n       (rst_n),
		.trace_reset (trace_reset),
		.badge_stb   (ibadge_stb),
		.badge_data  (ibadge_data),
		.lb_clk      (clk),
		.lb_addr     (addr.rd.index[TRACE_AW-1:0]),
		.lb_rd       (lb_rd),
		.lb_result   (ibadge_word)
	);

	// Output badges already on the bus clock
	badge_trace #(
		.TRACE_AW(TRACE_AW)
	) u_obadge_trace (
		.badge_clk   (clk),
		.rst_n       (rst_n),
		.trace_reset (trace_reset),
		.badge_stb   (obadge_stb),
		.badge_data  (obadge_data),
		.lb_clk      (clk),
		.lb_addr     (addr.rd.index[TRACE_AW-1:0]),
		.lb_rd       (lb_rd),
		.lb_result   (obadge_word)
	);

endmodule

`default_nettype wire

// File: verification/lb_demo_tb_tasks.svh
// Local-bus read and write tasks
// Directed tests for ID words, faults, LEDs, frequency and traces
`ifndef LB_DEMO_TB_TASKS_SVH
`define LB_DEMO_TB_TASKS_SVH

// Strobe on a falling edge and sample two edges later
task automatic bus_read(input logic [7:0] region, input logic [3:0] index,
	output logic [31:0] data);
	@(negedge clk);
	addr           = {region, 12'h000, index};
	control_strobe = 1'b1;
	control_rd     = 1'b1;
	@(negedge clk);
	control_strobe = 1'b0;
	// Second stage has landed by now
	@(negedge clk);
	data = data_in;
endtask

task automatic bus_write(input logic [3:0] page, input logic [3:0] index,
	input logic [31:0] data);
	@(negedge clk);
	addr           = {page, 16'h0000, index};
	control_strobe = 1'b1;
	control_rd     = 1'b0;
	data_out       = data;
	@(negedge clk);
	control_strobe = 1'b0;
endtask

// Two reads on consecutive cycles
task automatic read_pair(input logic [7:0] region_a, input logic [3:0] index_a,
	input logic [7:0] region_b, input logic [3:0] index_b,
	output logic [31:0] first, output logic [31:0] second);
	@(negedge clk);
	addr           = {region_a, 12'h000, index_a};
	control_strobe = 1'b1;
	control_rd     = 1'b1;
	@(negedge clk);
	addr = {region_b, 12'h000, index_b};
	@(negedge clk);
	control_strobe = 1'b0;
	first = data_in;
	@(negedge clk);
	second = data_in;
endtask

// Poll the count field of a trace until it matches
task automatic wait_trace_count(input logic [7:0] region, input int want,
	input string label);
	logic [31:0] word;
	int          polls;
	polls = 0;
	bus_read(region, 4'd0, word);
	while (word[15:8] != want && polls < TRACE_POLLS) begin
		bus_read(region, 4'd0, word);
		polls++;
	end
	if (word[15:8] != want) begin
		report_timeout($sformatf("%s trace count to reach %0d", label, want));
	end
endtask

// High cycles of both PWM LEDs over one full period
task automatic count_led_high(output int hi1, output int hi2);
	hi1 = 0;
	hi2 = 0;
	repeat (1024) begin
		@(negedge clk);
		hi1 += int'(led1);
		hi2 += int'(led2);
	end
endtask

task automatic verify_id_reads();
	logic [31:0] word;
	logic [31:0] first;
	logic [31:0] second;
	for (int i = 0; i < 16; i++) begin
		// Health words live at 4..6
		if (i >= 4 && i <= 6) begin
			continue;
		end
		bus_read(REGION_BANK0, 4'(i), word);
		check_value($sformatf("bank0 index %0d", i), word, id_word_for(i));
	end
	bus_read(8'h05, 4'd0, word);
	check_value("unmapped region 0x05", word, 32'hdeadbeef);
	read_pair(REGION_BANK0, 4'd2, REGION_BANK0, 4'd3, first, second);
	check_value("pipelined read index 2", first, id_word_for(2));
	check_value("pipelined read index 3", second, id_word_for(3));
	read_pair(8'h05, 4'd1, REGION_BANK0, 4'd0, first, second);
	check_value("pipelined unmapped read", first, 32'hdeadbeef);
	check_value("pipelined read index 0", second, id_word_for(0));
	// Read data holds across a write that moves the address
	bus_read(REGION_BANK0, 4'd1, word);
	bus_write(4'd1, 4'd0, 32'd0);
	@(negedge clk);
	check_value("read data held after write", data_in, id_word_for(1));
endtask

task automatic count_faults();
	int          pulses;
	logic [31:0] word;
	pulses = 1 + ($urandom % 40);
	@(negedge clk);
	// High for exactly that many rising edges
	xdomain_fault = 1'b1;
	repeat (pulses) @(negedge clk);
	xdomain_fault = 1'b0;
	bus_read(REGION_BANK0, 4'd4, word);
	check_value("fault counter", word, pulses);
	tx_mac_done = 1'b1;
	bus_read(REGION_BANK0, 4'd6, word);
	check_value("tx done set", word, 32'd1);
	tx_mac_done = 1'b0;
	bus_read(REGION_BANK0, 4'd6, word);
	check_value("tx done clear", word, 32'd0);
endtask

task automatic exercise_leds();
	logic [7:0] df1;
	logic [7:0] df2;
	int         hi1;
	int         hi2;
	df1 = 8'($urandom);
	df2 = 8'($urandom);
	bus_write(PAGE_CTRL, WREG_LED_USER, 32'd1);
	@(negedge clk);
	check_value("user LED on", led_user_mode, 32'd1);
	bus_write(PAGE_CTRL, WREG_LED1_DF, df1);
	bus_write(PAGE_CTRL, WREG_LED2_DF, df2);
	// Let the registered compare pick up the new duty
	repeat (2) @(negedge clk);
	count_led_high(hi1, hi2);
	check_value("led1 high cycles", hi1, 4 * int'(df1));
	check_value("led2 high cycles", hi2, 4 * int'(df2));
	// Page 1 has no registers
	bus_write(4'd1, WREG_LED_USER, 32'd0);
	bus_write(4'd1, WREG_LED1_DF, ~df1);
	repeat (2) @(negedge clk);
	check_value("user LED after page 1 write", led_user_mode, 32'd1);
	count_led_high(hi1, hi2);
	check_value("led1 after page 1 write", hi1, 4 * int'(df1));
	bus_write(PAGE_CTRL, WREG_LED_USER, 32'd0);
	@(negedge clk);
	check_value("user LED off", led_user_mode, 32'd0);
endtask

task automatic measure_frequency();
	logic [31:0] word;
	int          exp_freq;
	int          polls;
	bit          settled;
	// Badge edges per window of 2^REFCNT_W bus cycles
	exp_freq = ((2 ** REFCNT_W) * CLK_PERIOD) / BADGE_PERIOD;
	settled  = 1'b0;
	polls    = 0;
	while (!settled && polls < FREQ_POLLS) begin
		bus_read(REGION_BANK0, 4'd5, word);
		if (word >= exp_freq - 2 && word <= exp_freq + 2) begin
			settled = 1'b1;
		end else begin
			repeat (64) @(negedge clk);
		end
		polls++;
	end
	checks++;
	assert (settled) else begin
		errors++;
		$display("ERROR %0t ns: frequency read %0d, expected %0d +/- 2",
			$time, word, exp_freq);
	end
endtask

task automatic replay_badge_traces();
	logic [7:0]  ib [16];
	logic [7:0]  ob [16];
	logic [31:0] word;
	int          n;
	n = 1 + ($urandom % 12);
	for (int i = 0; i < n; i++) begin
		ib[i] = 8'($urandom);
		ob[i] = 8'($urandom);
	end
	// Input badges on their own clock
	for (int i = 0; i < n; i++) begin
		@(negedge ibadge_clk);
		ibadge_stb  = 1'b1;
		ibadge_data = ib[i];
	end
	@(negedge ibadge_clk);
	ibadge_stb = 1'b0;
	for (int i = 0; i < n; i++) begin
		@(negedge clk);
		obadge_stb  = 1'b1;
		obadge_data = ob[i];
	end
	@(negedge clk);
	obadge_stb = 1'b0;
	wait_trace_count(REGION_IBADGE, n, "input");
	wait_trace_count(REGION_OBADGE, n, "output");
	for (int i = 0; i < n; i++) begin
		bus_read(REGION_IBADGE, 4'(i), word);
		check_value($sformatf("input trace entry %0d", i), word, {16'h0000, 8'(n), ib[i]});
		bus_read(REGION_OBADGE, 4'(i), word);
		check_value($sformatf("output trace entry %0d", i), word, {16'h0000, 8'(n), ob[i]});
	end
	// Debug reset clears both traces
	bus_write(PAGE_CTRL, WREG_DBG_RST, 32'd1);
	wait_trace_count(REGION_IBADGE, 0, "cleared input");
	wait_trace_count(REGION_OBADGE, 0, "cleared output");
	bus_write(PAGE_CTRL, WREG_DBG_RST, 32'd0);
	repeat (8) @(negedge clk);
	bus_read(REGION_IBADGE, 4'd0, word);
	check_value("input count after debug reset", word[15:8], 32'd0);
	bus_read(REGION_OBADGE, 4'd0, word);
	check_value("output count after debug reset", word[15:8], 32'd0);
endtask

`endif

// File: verification/lb_demo_tb.sv
// Testbench for the local-bus demo peripheral
// Bus and badge clocks, reset, DUT and error counters
// Runs the directed tests and prints the result
`timescale 1ns/10ps
`default_nettype none

module lb_demo_tb
	import lb_bus_pkg::*;
	import lb_diag_pkg::*;
();

	// Clock periods in ns
	localparam int CLK_PERIOD   = 8;
	localparam int BADGE_PERIOD = 10;
	// Short gate window for simulation
	localparam int REFCNT_W     = 10;
	localparam int SEED         = 53078;
	// Poll limits for the waits on slow results
	localparam int FREQ_POLLS   = 64;
	localparam int TRACE_POLLS  = 32;

	logic               clk;
	logic               rst_n;
	logic [LB_AW-1:0]   addr;
	logic               control_strobe;
	logic               control_rd;
	logic [LB_DW-1:0]   data_out;
	logic [LB_DW-1:0]   data_in;
	logic               ibadge_clk;
	logic               ibadge_stb;
	logic [BADGE_W-1:0] ibadge_data;
	logic               obadge_stb;
	logic [BADGE_W-1:0] obadge_data;
	logic               xdomain_fault;
	logic               tx_mac_done;
	logic               led_user_mode;
	logic               led1;
	logic               led2;

	int checks   = 0;
	int errors   = 0;
	int timeouts = 0;

	lb_demo_top #(
		.REFCNT_WIDTH(REFCNT_W)
	) DUT (
		.clk            (clk),
		.rst_n          (rst_n),
		.addr           (addr),
		.control_strobe (control_strobe),
		.control_rd     (control_rd),
		.data_out       (data_out),
		.data_in        (data_in),
		.ibadge_clk     (ibadge_clk),
		.ibadge_stb     (ibadge_stb),
		.ibadge_data    (ibadge_data),
		.obadge_stb     (obadge_stb),
		.obadge_data    (obadge_data),
		.xdomain_fault  (xdomain_fault),
		.tx_mac_done    (tx_mac_done),
		.led_user_mode  (led_user_mode),
		.led1           (led1),
		.led2           (led2)
	);

	// Bus clock
	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Badge clock, also the one being measured
	initial begin
		ibadge_clk = 1'b0;
		forever #(BADGE_PERIOD / 2) ibadge_clk = ~ibadge_clk;
	end

	// Compare one value and log a mismatch
	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %0t ns: %s read 0x%h, expected 0x%h", $time, what, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		timeouts++;
		$display("Timed out at %0t ns while waiting for %s", $time, what);
	endtask

	// Bank-0 identification words
	function automatic logic [31:0] id_word_for(input int index);
		case (index)
			0:       return "Hell";
			1:       return "o wo";
			2:       return "rld!";
			3:       return "(::)";
			default: return "zzzz";
		endcase
	endfunction

	`include "lb_demo_tb_tasks.svh"

	initial begin
		void'($urandom(SEED));
		rst_n          = 1'b0;
		addr           = '0;
		control_strobe = 1'b0;
		control_rd     = 1'b0;
		data_out       = '0;
		ibadge_stb     = 1'b0;
		ibadge_data    = '0;
		obadge_stb     = 1'b0;
		obadge_data    = '0;
		xdomain_fault  = 1'b0;
		tx_mac_done    = 1'b0;
		// Hold reset for 8 bus cycles
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		repeat (4) @(negedge clk);

		verify_id_reads();
		count_faults();
		exercise_leds();
		measure_frequency();
		replay_badge_traces();

		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: lb_demo_top.f
src/lb_bus_pkg.sv
src/lb_diag_pkg.sv
src/freq_count.sv
src/badge_trace.sv
src/lb_demo_slave.sv
src/lb_demo_top.sv
+incdir+verification
verification/lb_demo_tb.sv

// File: Bender.yml
package:
  name: lb_demo

sources:
  # Packages first, then blocks, then the top level
  - files:
      - src/lb_bus_pkg.sv
      - src/lb_diag_pkg.sv
      - src/freq_count.sv
      - src/badge_trace.sv
      - src/lb_demo_slave.sv
      - src/lb_demo_top.sv

  # Testbench
  - target: test
    include_dirs:
      - verification
    files:
      - verification/lb_demo_tb.sv
